// File: common/merge_pkg.sv
package merge_pkg;

    // --------------------
    // Packet geometry
    // --------------------

    // One data field carried by a lane
    localparam int FIELD_W = 32;

    // Data fields per engine packet
    localparam int NUM_FIELDS = 4;

    // Route metadata width
    localparam int META_W = 16;

    typedef logic [FIELD_W-1:0] field_t;

    // Whole engine packet, meta in the upper bits
    typedef struct packed {
        logic [META_W-1:0]            meta;
        field_t [NUM_FIELDS-1:0]      field;
    } packet_t;

    // --------------------
    // Controller states
    // --------------------
    typedef enum logic [2:0] {
        MERGE_RESET,
        MERGE_IDLE,
        MERGE_SETUP_WAIT,
        MERGE_SETUP_REQ,
        MERGE_SETUP,
        MERGE_START,
        MERGE_BUSY,
        MERGE_PAUSE
    } merge_state_t;

    // --------------------
    // Top level defaults
    // --------------------

    // Extra lanes, at most NUM_FIELDS - 1
    localparam int MERGE_WIDTH_DEFAULT = 3;

    localparam int FIFO_DEPTH_DEFAULT = 16;

    // Output FIFO level that stops popping
    localparam int PROG_THRESH_DEFAULT = 8;

endpackage : merge_pkg

// File: merge_generator/merge_control.sv
module merge_control #(
    parameter int MERGE_WIDTH = merge_pkg::MERGE_WIDTH_DEFAULT
) (
    input  logic                   ap_clk,
    input  logic                   areset_generator,
    input  logic                   descriptor_valid,
    input  logic                   config_rd_en,
    input  logic                   config_valid,
    input  logic [MERGE_WIDTH:1]   config_mask,
    input  logic                   out_prog_full,
    input  logic                   all_empty,
    output logic                   config_request,
    output logic                   merge_enable,
    output logic [MERGE_WIDTH:1]   merge_mask,
    output logic                   done
);

    import merge_pkg::*;

    merge_state_t state;
    merge_state_t next_state;
    logic         enabled;

    // --------------------
    // State register
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= MERGE_RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            MERGE_RESET: begin
                next_state = MERGE_IDLE;
            end
            MERGE_IDLE: begin
                if (descriptor_valid) begin
                    next_state = MERGE_SETUP_WAIT;
                end
            end
            // Hold until configuration may be read
            MERGE_SETUP_WAIT: begin
                if (config_rd_en) begin
                    next_state = MERGE_SETUP_REQ;
                end
            end
            MERGE_SETUP_REQ: begin
                next_state = MERGE_SETUP;
            end
            MERGE_SETUP: begin
                if (config_valid) begin
                    next_state = MERGE_START;
                end
            end
            MERGE_START: begin
                next_state = MERGE_BUSY;
            end
            MERGE_BUSY: begin
                if (out_prog_full) begin
                    next_state = MERGE_PAUSE;
                end
            end
            MERGE_PAUSE: begin
                if (!out_prog_full) begin
                    next_state = MERGE_BUSY;
                end
            end
            default: begin
                next_state = MERGE_RESET;
            end
        endcase
    end

    assign enabled = (state == MERGE_START) || (state == MERGE_BUSY) || (state == MERGE_PAUSE);

    // --------------------
    // Registered outputs
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            config_request <= 1'b0;
            merge_enable   <= 1'b0;
            merge_mask     <= '0;
            done           <= 1'b0;
        end else begin
            // High for the first cycle spent in setup
            config_request <= (state == MERGE_SETUP_REQ);
            // Two cycles after config_valid, dropped again while paused
            merge_enable   <= (state == MERGE_START) || (state == MERGE_BUSY);
            if ((state == MERGE_SETUP) && config_valid) begin
                merge_mask <= config_mask;
            end
            done <= ((state == MERGE_IDLE) || enabled) && all_empty;
        end
    end

endmodule : merge_control

// File: merge_generator/merge_field_combine.sv
module merge_field_combine #(
    parameter int MERGE_WIDTH = merge_pkg::MERGE_WIDTH_DEFAULT
) (
    input  logic                                   ap_clk,
    input  logic                                   areset_generator,
    input  logic                                   lane_pop,
    input  merge_pkg::packet_t                     lane0_head,
    input  merge_pkg::field_t [MERGE_WIDTH:1]      lane_heads,
    input  logic [MERGE_WIDTH:1]                   merge_mask,
    output logic                                   out_wr_en,
    output merge_pkg::packet_t                     out_packet
);

    import merge_pkg::*;

    // Write strobe follows the pop by one cycle
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            out_wr_en <= 1'b0;
        end else begin
            out_wr_en <= lane_pop;
        end
    end

    // --------------------
    // Field selection
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (lane_pop) begin
            out_packet.meta     <= lane0_head.meta;
            out_packet.field[0] <= lane0_head.field[0];

            // Mergeable fields, lane k when its mask bit is set
            for (int k = 1; k <= MERGE_WIDTH; k++) begin
                if (merge_mask[k]) begin
                    out_packet.field[k] <= lane_heads[k];
                end else begin
                    out_packet.field[k] <= lane0_head.field[k];
                end
            end

            // Fields beyond the extra lanes pass through
            for (int k = MERGE_WIDTH + 1; k < NUM_FIELDS; k++) begin
                out_packet.field[k] <= lane0_head.field[k];
            end
        end
    end

endmodule : merge_field_combine

// File: merge_generator/merge_lane_gather.sv
module merge_lane_gather #(
    parameter int MERGE_WIDTH = merge_pkg::MERGE_WIDTH_DEFAULT,
    parameter int FIFO_DEPTH  = merge_pkg::FIFO_DEPTH_DEFAULT,
    parameter int PROG_THRESH = merge_pkg::PROG_THRESH_DEFAULT
) (
    input  logic                                   ap_clk,
    input  logic                                   areset_generator,
    input  logic                                   lane0_valid,
    input  merge_pkg::packet_t                     lane0_packet,
    input  logic [MERGE_WIDTH:1]                   lane_valid,
    input  merge_pkg::field_t [MERGE_WIDTH:1]      lane_field,
    input  logic                                   merge_enable,
    input  logic [MERGE_WIDTH:1]                   merge_mask,
    input  logic                                   out_prog_full,
    output logic                                   lane0_full,
    output logic [MERGE_WIDTH:1]                   lane_full,
    output logic                                   lane_pop,
    output merge_pkg::packet_t                     lane0_head,
    output merge_pkg::field_t [MERGE_WIDTH:1]      lane_heads,
    output logic                                   lanes_empty
);

    import merge_pkg::*;

    logic                 lane0_empty;
    logic [MERGE_WIDTH:1] lane_empty;
    logic [MERGE_WIDTH:1] lane_blocked;
    logic [MERGE_WIDTH:1] lane_rd_en;

    // --------------------
    // Lane 0, whole packets
    // --------------------
    sync_fifo #(
        .payload_t   (packet_t),
        .FIFO_DEPTH  (FIFO_DEPTH),
        .PROG_THRESH (PROG_THRESH)
    ) lane0_fifo_i (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .wr_en            (lane0_valid),
        .din              (lane0_packet),
        .rd_en            (lane_pop),
        .dout             (lane0_head),
        .full             (lane0_full),
        .empty            (lane0_empty),
        .prog_full        ()
    );

    // --------------------
    // Extra lanes, one field each
    // --------------------
    for (genvar k = 1; k <= MERGE_WIDTH; k++) begin : g_lane
        // Unmasked lanes keep their data
        assign lane_rd_en[k] = lane_pop & merge_mask[k];

        sync_fifo #(
            .payload_t   (field_t),
            .FIFO_DEPTH  (FIFO_DEPTH),
            .PROG_THRESH (PROG_THRESH)
        ) lane_fifo_i (
            .ap_clk           (ap_clk),
            .areset_generator (areset_generator),
            .wr_en            (lane_valid[k]),
            .din              (lane_field[k]),
            .rd_en            (lane_rd_en[k]),
            .dout             (lane_heads[k]),
            .full             (lane_full[k]),
            .empty            (lane_empty[k]),
            .prog_full        ()
        );
    end

    // A masked lane with nothing buffered stalls the merge
    assign lane_blocked = merge_mask & lane_empty;

    assign lane_pop = merge_enable & ~out_prog_full & ~lane0_empty & ~(|lane_blocked);

    assign lanes_empty = lane0_empty & (&lane_empty);

endmodule : merge_lane_gather

// File: project.f
common/merge_pkg.sv
rtl/sync_fifo.sv
merge_generator/merge_control.sv
merge_generator/merge_lane_gather.sv
merge_generator/merge_field_combine.sv
rtl/merge_data_generator.sv
verification/merge_data_generator_sva.sv
verification/merge_data_generator_tb.sv

// File: rtl/merge_data_generator.sv
module merge_data_generator #(
    parameter int MERGE_WIDTH = merge_pkg::MERGE_WIDTH_DEFAULT,
    parameter int FIFO_DEPTH  = merge_pkg::FIFO_DEPTH_DEFAULT,
    parameter int PROG_THRESH = merge_pkg::PROG_THRESH_DEFAULT
) (
    input  logic                                   ap_clk,
    input  logic                                   areset_generator,
    input  logic                                   descriptor_valid,
    input  logic                                   config_rd_en,
    input  logic                                   config_valid,
    input  logic [MERGE_WIDTH:1]                   config_mask,
    input  logic                                   lane0_valid,
    input  merge_pkg::packet_t                     lane0_packet,
    input  logic [MERGE_WIDTH:1]                   lane_valid,
    input  merge_pkg::field_t [MERGE_WIDTH:1]      lane_field,
    input  logic                                   request_ready,
    output logic                                   lane0_full,
    output logic [MERGE_WIDTH:1]                   lane_full,
    output logic                                   config_request,
    output logic                                   request_valid,
    output merge_pkg::packet_t                     request_packet,
    output logic                                   done
);

    import merge_pkg::*;

    logic                       merge_enable;
    logic [MERGE_WIDTH:1]       merge_mask;
    logic                       lane_pop;
    packet_t                    lane0_head;
    field_t [MERGE_WIDTH:1]     lane_heads;
    logic                       lanes_empty;
    logic                       out_wr_en;
    packet_t                    out_packet;
    logic                       out_empty;
    logic                       out_prog_full;
    logic                       all_empty;

    if (MERGE_WIDTH > NUM_FIELDS - 1) begin : g_width_check
        $error("MERGE_WIDTH exceeds the number of mergeable fields");
    end

    assign all_empty = lanes_empty & out_empty;

    // --------------------
    // Control
    // --------------------
    merge_control #(
        .MERGE_WIDTH (MERGE_WIDTH)
    ) merge_control_i (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .descriptor_valid (descriptor_valid),
        .config_rd_en     (config_rd_en),
        .config_valid     (config_valid),
        .config_mask      (config_mask),
        .out_prog_full    (out_prog_full),
        .all_empty        (all_empty),
        .config_request   (config_request),
        .merge_enable     (merge_enable),
        .merge_mask       (merge_mask),
        .done             (done)
    );

    // --------------------
    // Datapath
    // --------------------
    merge_lane_gather #(
        .MERGE_WIDTH (MERGE_WIDTH),
        .FIFO_DEPTH  (FIFO_DEPTH),
        .PROG_THRESH (PROG_THRESH)
    ) merge_lane_gather_i (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .lane0_valid      (lane0_valid),
        .lane0_packet     (lane0_packet),
        .lane_valid       (lane_valid),
        .lane_field       (lane_field),
        .merge_enable     (merge_enable),
        .merge_mask       (merge_mask),
        .out_prog_full    (out_prog_full),
        .lane0_full       (lane0_full),
        .lane_full        (lane_full),
        .lane_pop         (lane_pop),
        .lane0_head       (lane0_head),
        .lane_heads       (lane_heads),
        .lanes_empty      (lanes_empty)
    );

    merge_field_combine #(
        .MERGE_WIDTH (MERGE_WIDTH)
    ) merge_field_combine_i (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .lane_pop         (lane_pop),
        .lane0_head       (lane0_head),
        .lane_heads       (lane_heads),
        .merge_mask       (merge_mask),
        .out_wr_en        (out_wr_en),
        .out_packet       (out_packet)
    );

    // Output FIFO, popped on every accepted request
    sync_fifo #(
        .payload_t   (packet_t),
        .FIFO_DEPTH  (FIFO_DEPTH),
        .PROG_THRESH (PROG_THRESH)
    ) out_fifo_i (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .wr_en            (out_wr_en),
        .din              (out_packet),
        .rd_en            (request_valid),
        .dout             (request_packet),
        .full             (),
        .empty            (out_empty),
        .prog_full        (out_prog_full)
    );

    assign request_valid = ~out_empty & request_ready;

endmodule : merge_data_generator

// File: rtl/sync_fifo.sv
module sync_fifo #(
    parameter type payload_t   = merge_pkg::field_t,
    parameter int  FIFO_DEPTH  = merge_pkg::FIFO_DEPTH_DEFAULT,
    parameter int  PROG_THRESH = merge_pkg::PROG_THRESH_DEFAULT
) (
    input  logic     ap_clk,
    input  logic     areset_generator,
    input  logic     wr_en,
    input  payload_t din,
    input  logic     rd_en,
    output payload_t dout,
    output logic     full,
    output logic     empty,
    output logic     prog_full
);

    localparam int ADDR_W  = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int COUNT_W = $clog2(FIFO_DEPTH + 1);

    localparam logic [ADDR_W-1:0]  LAST_ADDR    = ADDR_W'(FIFO_DEPTH - 1);
    localparam logic [COUNT_W-1:0] DEPTH_COUNT  = COUNT_W'(FIFO_DEPTH);
    localparam logic [COUNT_W-1:0] THRESH_COUNT = COUNT_W'(PROG_THRESH);

    payload_t           mem [FIFO_DEPTH];
    logic [ADDR_W-1:0]  wr_ptr;
    logic [ADDR_W-1:0]  rd_ptr;
    logic [COUNT_W-1:0] count;
    logic               do_write;
    logic               do_read;

    // Writes to a full FIFO and reads from an empty one are dropped
    assign do_write = wr_en & ~full;
    assign do_read  = rd_en & ~empty;

    always_ff @(posedge ap_clk) begin
        if (do_write) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == LAST_ADDR) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == LAST_ADDR) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // First word falls through, head is valid whenever not empty
    assign dout      = mem[rd_ptr];
    assign full      = (count == DEPTH_COUNT);
    assign empty     = (count == '0);
    assign prog_full = (count >= THRESH_COUNT);

endmodule : sync_fifo

// File: run_sim.sh
#!/bin/sh
# Build and run the merge data generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module merge_data_generator_tb
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

output=$(./obj_dir/Vmerge_data_generator_tb +verilator+error+limit+100)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Result: PASSED$"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: verification/merge_data_generator_sva.sv
module merge_data_generator_sva (
    input logic ap_clk,
    input logic areset_generator,
    input logic descriptor_valid,
    input logic config_valid,
    input logic config_request,
    input logic merge_enable
);

    timeunit 1ns;
    timeprecision 1ps;

    int   fail_count = 0;
    logic desc_seen;
    logic cfg_seen;

    // Job history since the last reset
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            desc_seen <= 1'b0;
            cfg_seen  <= 1'b0;
        end else begin
            if (descriptor_valid) begin
                desc_seen <= 1'b1;
            end
            if (config_valid) begin
                cfg_seen <= 1'b1;
            end
        end
    end

    // --------------------
    // Control properties
    // --------------------
    a_request_pulse: assert property (@(posedge ap_clk) disable iff (areset_generator)
        config_request |=> !config_request)
        else begin
            fail_count++;
            $error("config_request high for more than one cycle");
        end

    a_request_needs_descriptor: assert property (@(posedge ap_clk) disable iff (areset_generator)
        config_request |-> desc_seen)
        else begin
            fail_count++;
            $error("config_request without a descriptor since reset");
        end

    a_enable_needs_config: assert property (@(posedge ap_clk) disable iff (areset_generator)
        merge_enable |-> cfg_seen)
        else begin
            fail_count++;
            $error("merge_enable high before config_valid");
        end

endmodule : merge_data_generator_sva

bind merge_control merge_data_generator_sva merge_data_generator_sva_i (
    .ap_clk           (ap_clk),
    .areset_generator (areset_generator),
    .descriptor_valid (descriptor_valid),
    .config_valid     (config_valid),
    .config_request   (config_request),
    .merge_enable     (merge_enable)
);

// File: verification/merge_data_generator_tb.sv
module merge_data_generator_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import merge_pkg::*;

    localparam int MERGE_WIDTH  = MERGE_WIDTH_DEFAULT;
    localparam int FIFO_DEPTH   = FIFO_DEPTH_DEFAULT;
    localparam int PROG_THRESH  = PROG_THRESH_DEFAULT;
    localparam int PKT_W        = $bits(packet_t);
    localparam int N_ORDER      = 12;
    localparam int N_BP         = 10;
    localparam int N_MASK       = FIFO_DEPTH;
    localparam int N_STALL      = FIFO_DEPTH;
    localparam int STALL_CYCLES = 20;
    localparam int WAIT_LIMIT   = 200;
    // Each push takes about three cycles, plus setup, stalls and drain
    localparam int WATCHDOG_CYCLES =
        6 * (N_ORDER + N_BP + N_MASK + 2 * N_STALL) + 2 * STALL_CYCLES + 400;

    logic                   ap_clk;
    logic                   areset_generator;
    logic                   descriptor_valid;
    logic                   config_rd_en;
    logic                   config_valid;
    logic [MERGE_WIDTH:1]   config_mask;
    logic                   lane0_valid;
    packet_t                lane0_packet;
    logic [MERGE_WIDTH:1]   lane_valid;
    field_t [MERGE_WIDTH:1] lane_field;
    logic                   request_ready;
    logic                   lane0_full;
    logic [MERGE_WIDTH:1]   lane_full;
    logic                   config_request;
    logic                   request_valid;
    packet_t                request_packet;
    logic                   done;

    // Reference model state
    packet_t                lane0_q [$];
    field_t                 lane_q [1:MERGE_WIDTH][$];
    logic [MERGE_WIDTH:1]   job_mask;
    integer                 seed;
    int                     errors;
    int                     test_errors;
    int                     tests_run;
    int                     tests_failed;
    int                     pushed;
    int                     out_count;
    int                     req_pulses;

    merge_data_generator #(
        .MERGE_WIDTH (MERGE_WIDTH),
        .FIFO_DEPTH  (FIFO_DEPTH),
        .PROG_THRESH (PROG_THRESH)
    ) merge_data_generator_i (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .descriptor_valid (descriptor_valid),
        .config_rd_en     (config_rd_en),
        .config_valid     (config_valid),
        .config_mask      (config_mask),
        .lane0_valid      (lane0_valid),
        .lane0_packet     (lane0_packet),
        .lane_valid       (lane_valid),
        .lane_field       (lane_field),
        .request_ready    (request_ready),
        .lane0_full       (lane0_full),
        .lane_full        (lane_full),
        .config_request   (config_request),
        .request_valid    (request_valid),
        .request_packet   (request_packet),
        .done             (done)
    );

    initial ap_clk = 1'b0;
    always #10 ap_clk = ~ap_clk;

    task automatic check_value(input logic [PKT_W-1:0] actual, input logic [PKT_W-1:0] expected,
                               input string what);
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // Predict one output from the lane queues by the mask rule
    task automatic compare_output();
        packet_t exp;
        if (lane0_q.size() == 0) begin
            errors++;
            $display("At %0t an output packet appeared with no lane 0 packet pending", $time);
        end else begin
            exp = lane0_q.pop_front();
            for (int k = 1; k <= MERGE_WIDTH; k++) begin
                if (job_mask[k] && lane_q[k].size() == 0) begin
                    errors++;
                    $display("At %0t lane %0d was merged without any pushed field", $time, k);
                end else if (job_mask[k]) begin
                    exp.field[k] = lane_q[k].pop_front();
                end
            end
            check_value(request_packet, exp, "output packet");
        end
        out_count++;
    endtask

    // --------------------
    // Output monitor
    // --------------------
    always @(negedge ap_clk) begin
        if (areset_generator) begin
            out_count  = 0;
            req_pulses = 0;
        end else begin
            if (config_request) begin
                req_pulses++;
            end
            if (request_valid) begin
                compare_output();
            end
        end
    end

    task automatic reset_dut();
        @(posedge ap_clk);
        areset_generator <= 1'b1;
        descriptor_valid <= 1'b0;
        config_rd_en     <= 1'b0;
        config_valid     <= 1'b0;
        lane0_valid      <= 1'b0;
        lane_valid       <= '0;
        request_ready    <= 1'b1;
        lane0_q.delete();
        for (int k = 1; k <= MERGE_WIDTH; k++) begin
            lane_q[k].delete();
        end
        pushed = 0;
        repeat (4) @(posedge ap_clk);
        areset_generator <= 1'b0;
    endtask

    task automatic start_job(input logic [MERGE_WIDTH:1] mask);
        int cycles;
        cycles = 0;
        @(posedge ap_clk);
        descriptor_valid <= 1'b1;
        config_rd_en     <= 1'b1;
        @(posedge ap_clk);
        descriptor_valid <= 1'b0;
        @(negedge ap_clk);
        while (!config_request && cycles < WAIT_LIMIT) begin
            @(negedge ap_clk);
            cycles++;
        end
        if (!config_request) begin
            errors++;
            $display("Timed out at %0t waiting for config_request", $time);
        end
        @(posedge ap_clk);
        config_valid <= 1'b1;
        config_mask  <= mask;
        job_mask = mask;
        @(posedge ap_clk);
        config_valid <= 1'b0;
    endtask

    task automatic make_random(output packet_t pkt, output field_t [MERGE_WIDTH:1] flds);
        logic [31:0] r;
        r = $random(seed);
        pkt.meta = r[META_W-1:0];
        for (int i = 0; i < NUM_FIELDS; i++) begin
            pkt.field[i] = $random(seed);
        end
        for (int k = 1; k <= MERGE_WIDTH; k++) begin
            flds[k] = $random(seed);
        end
    endtask

    // One push strobe, held back while a target lane is full
    task automatic push_lanes(input packet_t pkt, input field_t [MERGE_WIDTH:1] flds,
                              input logic push0, input logic [MERGE_WIDTH:1] which);
        @(negedge ap_clk);
        while ((push0 && lane0_full) || ((lane_full & which) != '0)) begin
            @(negedge ap_clk);
        end
        @(posedge ap_clk);
        lane0_valid  <= push0;
        lane0_packet <= pkt;
        lane_valid   <= which;
        lane_field   <= flds;
        if (push0) begin
            lane0_q.push_back(pkt);
            pushed++;
        end
        for (int k = 1; k <= MERGE_WIDTH; k++) begin
            if (which[k]) begin
                lane_q[k].push_back(flds[k]);
            end
        end
        @(posedge ap_clk);
        lane0_valid <= 1'b0;
        lane_valid  <= '0;
    endtask

    task automatic push_random(input int count, input logic [MERGE_WIDTH:1] which);
        packet_t                pkt;
        field_t [MERGE_WIDTH:1] flds;
        for (int n = 0; n < count; n++) begin
            make_random(pkt, flds);
            push_lanes(pkt, flds, 1'b1, which);
        end
    endtask

    task automatic wait_outputs(input int target, input string what);
        int cycles;
        cycles = 0;
        while (out_count < target && cycles < WAIT_LIMIT) begin
            @(negedge ap_clk);
            cycles++;
        end
        if (out_count < target) begin
            errors++;
            $display("Timed out at %0t waiting for %s, %0d of %0d packets arrived",
                     $time, what, out_count, target);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors != test_errors) begin
            tests_failed++;
            $display("Test %s: %0d errors", name, errors - test_errors);
        end else begin
            $display("Test %s: ok", name);
        end
        test_errors = errors;
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        packet_t                pkt;
        field_t [MERGE_WIDTH:1] flds;
        logic [MERGE_WIDTH:1]   which;
        logic [31:0]            r;
        int                     stall;
        int                     base;
        int                     cycles;
        seed         = 32'h910e;
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        areset_generator <= 1'b1;
        descriptor_valid <= 1'b0;
        config_rd_en     <= 1'b0;
        config_valid     <= 1'b0;
        config_mask      <= '0;
        lane0_valid      <= 1'b0;
        lane0_packet     <= '0;
        lane_valid       <= '0;
        lane_field       <= '0;
        request_ready    <= 1'b1;
        reset_dut();

        @(negedge ap_clk);
        check_value(PKT_W'(done), '0, "done right after reset");
        repeat (5) begin
            @(negedge ap_clk);
            check_value(PKT_W'(request_valid), '0, "request_valid before a job");
            check_value(PKT_W'(config_request), '0, "config_request before a descriptor");
        end
        start_job('1);
        repeat (8) @(negedge ap_clk);
        check_value(PKT_W'(req_pulses), PKT_W'(1), "config_request pulse count");
        finish_test("config request");

        push_random(N_ORDER, '1);
        wait_outputs(pushed, "merged packets");
        finish_test("full mask order");

        @(posedge ap_clk);
        request_ready <= 1'b0;
        base = out_count;
        push_random(N_BP, '1);
        repeat (10) @(negedge ap_clk);
        check_value(PKT_W'(out_count), PKT_W'(base), "packets read while request_ready low");
        @(posedge ap_clk);
        request_ready <= 1'b1;
        wait_outputs(pushed, "packets after back-pressure");
        repeat (5) @(negedge ap_clk);
        check_value(PKT_W'(out_count), PKT_W'(pushed), "packets read after back-pressure");
        finish_test("back-pressure");

        // Hold back one masked lane until lane 0 fills up
        stall = ({$random(seed)} % MERGE_WIDTH) + 1;
        which = '1;
        which[stall] = 1'b0;
        push_random(N_STALL, which);
        repeat (STALL_CYCLES) begin
            @(negedge ap_clk);
            check_value(PKT_W'(request_valid), '0, "request_valid while a masked lane is empty");
        end
        check_value(PKT_W'(done), '0, "done while a lane holds data");
        check_value(PKT_W'(lane0_full), PKT_W'(1), "lane0_full with lane 0 stalled");
        check_value(PKT_W'(lane_full), PKT_W'(which), "lane_full with one lane stalled");
        which = '0;
        which[stall] = 1'b1;
        for (int n = 0; n < N_STALL; n++) begin
            make_random(pkt, flds);
            push_lanes(pkt, flds, 1'b0, which);
        end
        wait_outputs(pushed, "the stalled packets");
        finish_test("stalled lane");

        cycles = 0;
        while (!done && cycles < WAIT_LIMIT) begin
            @(negedge ap_clk);
            cycles++;
        end
        check_value(PKT_W'(done), PKT_W'(1), "done after draining");
        finish_test("done");

        // Second job with a random mask
        reset_dut();
        r = $random(seed);
        start_job(r[MERGE_WIDTH-1:0]);
        push_random(N_MASK, '1);
        wait_outputs(pushed, "packets under a random mask");
        repeat (3) @(negedge ap_clk);
        which = ~job_mask;
        check_value(PKT_W'(lane_full), PKT_W'(which), "unmasked lanes left full");
        finish_test("random mask");

        check_value(
            PKT_W'(merge_data_generator_i.merge_control_i.merge_data_generator_sva_i.fail_count),
            '0, "assertion failures");
        $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge ap_clk);
        $display("Watchdog expired at %0t, the tests did not finish in time", $time);
        $display("Result: FAILED");
        $finish;
    end

endmodule : merge_data_generator_tb
